// File: Bender.yml
package:
  name: fc_classifier

sources:
  # RTL in compile order
  - files:
      - rtl/fc_pkg.sv
      - rtl/fc_operand_if.sv
      - rtl/fc_acc_if.sv
      - rtl/fc_store.sv
      - rtl/fc_decode.sv
      - rtl/fc_execute.sv
      - rtl/fc_result.sv
      - rtl/fc_top.sv
  - target: simulation
    files:
      - sim/fc_tb.sv

// File: rtl/fc_acc_if.sv
interface fc_acc_if #(
    parameter int NRN_W = 3
) ();
    import fc_pkg::*;

    logic             acc_valid;
    fc_acc_t          acc;
    // Tags of the neuron the value belongs to
    logic             layer;
    logic [NRN_W-1:0] neuron;

    modport execute (
        output acc_valid, acc, layer, neuron
    );

    modport result (
        input acc_valid, acc, layer, neuron
    );

endinterface

// File: rtl/fc_decode.sv
module fc_decode #(
    parameter int N_IN    = 16,
    parameter int N_HID   = 8,
    parameter int N_OUT   = 4,
    parameter int WADDR_W = 6,
    parameter int FADDR_W = 3,
    parameter int NRN_W   = 3
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               start,
    input  logic               done,
    input  fc_pkg::fc_word_t   feature_rdata,
    input  fc_pkg::fc_word_t   weight_rdata,
    output logic               busy,
    output logic [FADDR_W-1:0] feature_raddr,
    output logic [WADDR_W-1:0] weight_raddr,
    fc_operand_if.decode       op
);
    import fc_pkg::*;

    // Weight memory layout in words
    localparam int B0_BASE = N_HID * N_IN / LANES;
    localparam int W1_BASE = B0_BASE + N_HID / LANES;
    localparam int B1_BASE = W1_BASE + N_OUT * N_HID / LANES;
    localparam int DRAIN_W = $clog2(DRAIN_CYCLES);

    fc_state_t          state;
    logic               layer;
    logic [NRN_W-1:0]   neuron;
    logic [NRN_W-1:0]   last_neuron;
    logic [FADDR_W-1:0] word;
    logic [FADDR_W-1:0] last_word;
    logic [FADDR_W-1:0] in_base;
    logic [WADDR_W-1:0] w_ptr;
    logic [WADDR_W-1:0] b_base;
    logic [DRAIN_W-1:0] drain_cnt;
    logic               launch;
    logic               iss_op;
    logic               iss_first;
    logic               iss_bias;
    logic               iss_layer;
    logic [1:0]         iss_lane;
    logic [NRN_W-1:0]   iss_neuron;

    // Per-layer sizes and bases
    always_comb begin
        if (layer) begin
            in_base     = FADDR_W'(N_IN / LANES);
            last_word   = FADDR_W'(N_HID / LANES - 1);
            last_neuron = NRN_W'(N_OUT - 1);
            b_base      = WADDR_W'(B1_BASE);
        end else begin
            in_base     = '0;
            last_word   = FADDR_W'(N_IN / LANES - 1);
            last_neuron = NRN_W'(N_HID - 1);
            b_base      = WADDR_W'(B0_BASE);
        end
    end

    // A start in the done cycle already counts as idle
    assign launch = start && (state == IDLE || (state == WAIT_DONE && done));
    assign busy   = (state != IDLE) && !done;

    assign feature_raddr = in_base + word;
    assign weight_raddr  = (state == BIAS) ? b_base + WADDR_W'(neuron >> 2) : w_ptr;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= IDLE;
            layer     <= 1'b0;
            neuron    <= '0;
            word      <= '0;
            w_ptr     <= '0;
            drain_cnt <= '0;
        end else if (launch) begin
            state  <= FETCH;
            layer  <= 1'b0;
            neuron <= '0;
            word   <= '0;
            w_ptr  <= '0;
        end else begin
            case (state)
                FETCH: begin
                    // Weights of consecutive neurons are contiguous
                    w_ptr <= w_ptr + 1'b1;
                    if (word == last_word) begin
                        word  <= '0;
                        state <= BIAS;
                    end else begin
                        word <= word + 1'b1;
                    end
                end
                BIAS: begin
                    if (neuron != last_neuron) begin
                        neuron <= neuron + 1'b1;
                        state  <= FETCH;
                    end else if (!layer) begin
                        neuron    <= '0;
                        layer     <= 1'b1;
                        w_ptr     <= WADDR_W'(W1_BASE);
                        drain_cnt <= '0;
                        state     <= DRAIN;
                    end else begin
                        neuron <= '0;
                        state  <= WAIT_DONE;
                    end
                end
                DRAIN: begin
                    if (drain_cnt == DRAIN_W'(DRAIN_CYCLES - 1)) begin
                        state <= FETCH;
                    end else begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                WAIT_DONE: begin
                    if (done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Issue strobes line up with the read latency
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            iss_op   <= 1'b0;
            iss_bias <= 1'b0;
        end else begin
            iss_op   <= (state == FETCH);
            iss_bias <= (state == BIAS);
        end
    end

    always_ff @(posedge clk) begin
        iss_first  <= (word == '0);
        iss_layer  <= layer;
        iss_neuron <= neuron;
        iss_lane   <= neuron[1:0];
    end

    assign op.op_valid   = iss_op;
    assign op.first      = iss_first;
    assign op.x_word     = feature_rdata;
    assign op.w_word     = weight_rdata;
    assign op.bias_valid = iss_bias;
    // Bias byte of this neuron within its word
    assign op.bias       = weight_rdata[iss_lane];
    assign op.layer      = iss_layer;
    assign op.neuron     = iss_neuron;

endmodule

// File: rtl/fc_execute.sv
module fc_execute (
    input  logic          clk,
    input  logic          rstn,
    fc_operand_if.execute op,
    fc_acc_if.execute     acc_out
);
    import fc_pkg::*;

    logic signed [15:0] prod [LANES];
    fc_acc_t            lane_sum;
    fc_acc_t            acc;

    // Four signed lane products summed per word
    always_comb begin
        lane_sum = '0;
        for (int i = 0; i < LANES; i++) begin
            prod[i]  = $signed(op.x_word[i]) * $signed(op.w_word[i]);
            lane_sum = lane_sum + prod[i];
        end
    end

    always_ff @(posedge clk) begin
        if (op.op_valid) begin
            // First word of a neuron restarts the sum
            acc <= op.first ? lane_sum : acc + lane_sum;
        end
        if (op.bias_valid) begin
            acc_out.acc    <= acc + op.bias;
            acc_out.layer  <= op.layer;
            acc_out.neuron <= op.neuron;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            acc_out.acc_valid <= 1'b0;
        end else begin
            acc_out.acc_valid <= op.bias_valid;
        end
    end

endmodule

// File: rtl/fc_operand_if.sv
interface fc_operand_if #(
    parameter int NRN_W = 3
) ();
    import fc_pkg::*;

    logic             op_valid;
    logic             first;
    fc_word_t         x_word;
    fc_word_t         w_word;
    logic             bias_valid;
    fc_byte_t         bias;
    logic             layer;
    logic [NRN_W-1:0] neuron;

    modport decode (
        output op_valid, first, x_word, w_word, bias_valid, bias, layer, neuron
    );

    modport execute (
        input op_valid, first, x_word, w_word, bias_valid, bias, layer, neuron
    );

endinterface

// File: rtl/fc_pkg.sv
package fc_pkg;

    // Number of int8 lanes carried in one memory word
    localparam int LANES = 4;

    // Cycles from the last layer-0 bias issue until its write-back is readable
    localparam int DRAIN_CYCLES = 3;

    // Signed activation, weight or bias
    typedef logic signed [7:0] fc_byte_t;

    // Four packed bytes, lane 0 in bits 7:0 holds the lowest index
    typedef fc_byte_t [LANES-1:0] fc_word_t;

    // Per-neuron accumulator
    typedef logic signed [31:0] fc_acc_t;

    // Layer sequencer states
    typedef enum logic [2:0] {
        // Waiting for start
        IDLE,
        // Data words of one neuron
        FETCH,
        // Bias word of the current neuron
        BIAS,
        // Hidden write-back settling before layer 1
        DRAIN,
        // Waiting for the argmax result
        WAIT_DONE
    } fc_state_t;

endpackage

// File: rtl/fc_result.sv
module fc_result #(
    parameter int N_IN    = 16,
    parameter int N_OUT   = 4,
    parameter int SHIFT   = 4,
    parameter int FADDR_W = 3,
    parameter int NRN_W   = 3
) (
    input  logic                     clk,
    input  logic                     rstn,
    fc_acc_if.result                 acc_in,
    output logic                     hid_we,
    output logic [FADDR_W-1:0]       hid_addr,
    output fc_pkg::fc_word_t         hid_data,
    output logic [$clog2(N_OUT)-1:0] class_out,
    output logic                     done
);
    import fc_pkg::*;

    localparam int CLS_W = $clog2(N_OUT);

    fc_acc_t          shifted;
    fc_byte_t         q;
    fc_word_t         pack_buf;
    fc_word_t         next_buf;
    fc_byte_t         max_val;
    logic [NRN_W-1:0] max_idx;
    logic [NRN_W-1:0] next_idx;
    logic [1:0]       lane;
    logic             take;
    logic             last_out;

    // Requantize with saturation, ReLU on the hidden layer
    always_comb begin
        shifted = acc_in.acc >>> SHIFT;
        if (shifted > 127) begin
            q = 8'sh7f;
        end else if (shifted < -128) begin
            q = 8'sh80;
        end else begin
            q = shifted[7:0];
        end
        if (!acc_in.layer && q < 0) begin
            q = '0;
        end
    end

    assign lane = acc_in.neuron[1:0];

    always_comb begin
        next_buf       = pack_buf;
        next_buf[lane] = q;
    end

    // Strictly greater keeps the lowest index on a tie
    assign take     = (acc_in.neuron == '0) || (q > max_val);
    assign next_idx = take ? acc_in.neuron : max_idx;
    assign last_out = (acc_in.neuron == NRN_W'(N_OUT - 1));

    always_ff @(posedge clk) begin
        if (acc_in.acc_valid && !acc_in.layer) begin
            pack_buf <= next_buf;
            hid_data <= next_buf;
            hid_addr <= FADDR_W'(N_IN / LANES) + FADDR_W'(acc_in.neuron >> 2);
        end else if (acc_in.acc_valid && take) begin
            max_val <= q;
            max_idx <= acc_in.neuron;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            hid_we    <= 1'b0;
            done      <= 1'b0;
            class_out <= '0;
        end else begin
            // Write the word once lane 3 is filled
            hid_we <= acc_in.acc_valid && !acc_in.layer && (lane == 2'd3);
            done   <= acc_in.acc_valid && acc_in.layer && last_out;
            if (acc_in.acc_valid && acc_in.layer && last_out) begin
                class_out <= CLS_W'(next_idx);
            end
        end
    end

endmodule

// File: rtl/fc_store.sv
module fc_store #(
    parameter int WADDR_W = 6,
    parameter int FADDR_W = 3
) (
    input  logic                 clk,
    input  logic                 rstn,
    // Load port, load_sel high selects the weight memory
    input  logic                 load_en,
    input  logic                 load_sel,
    input  logic [WADDR_W-1:0]   load_addr,
    input  fc_pkg::fc_word_t     load_data,
    // Read ports, data one cycle after the address
    input  logic [FADDR_W-1:0]   feature_raddr,
    input  logic [WADDR_W-1:0]   weight_raddr,
    output fc_pkg::fc_word_t     feature_rdata,
    output fc_pkg::fc_word_t     weight_rdata,
    // Hidden activation write-back
    input  logic                 hid_we,
    input  logic [FADDR_W-1:0]   hid_addr,
    input  fc_pkg::fc_word_t     hid_data
);
    import fc_pkg::*;

    fc_word_t feature_mem [2**FADDR_W];
    fc_word_t weight_mem  [2**WADDR_W];

    // Feature memory, the load port wins over write-back
    always_ff @(posedge clk) begin
        if (load_en && !load_sel) begin
            feature_mem[load_addr[FADDR_W-1:0]] <= load_data;
        end else if (hid_we) begin
            feature_mem[hid_addr] <= hid_data;
        end
    end

    // Weights and biases are only written from outside
    always_ff @(posedge clk) begin
        if (load_en && load_sel) begin
            weight_mem[load_addr] <= load_data;
        end
    end

    // Registered reads, old data on a same-cycle write
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            feature_rdata <= '0;
            weight_rdata  <= '0;
        end else begin
            feature_rdata <= feature_mem[feature_raddr];
            weight_rdata  <= weight_mem[weight_raddr];
        end
    end

endmodule

// File: rtl/fc_top.sv
module fc_top #(
    parameter int N_IN    = 16,
    parameter int N_HID   = 8,
    parameter int N_OUT   = 4,
    parameter int SHIFT   = 4,
    parameter int WADDR_W = 6,
    parameter int FADDR_W = 3
) (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     start,
    input  logic                     load_en,
    input  logic                     load_sel,
    input  logic [WADDR_W-1:0]       load_addr,
    input  fc_pkg::fc_word_t         load_data,
    output logic                     busy,
    output logic                     done,
    output logic [$clog2(N_OUT)-1:0] class_out
);
    import fc_pkg::*;

    // Wide enough for either layer's neuron index
    localparam int NRN_W = $clog2(N_HID > N_OUT ? N_HID : N_OUT);

    logic [FADDR_W-1:0] feature_raddr;
    logic [WADDR_W-1:0] weight_raddr;
    fc_word_t           feature_rdata;
    fc_word_t           weight_rdata;
    logic               hid_we;
    logic [FADDR_W-1:0] hid_addr;
    fc_word_t           hid_data;

    fc_operand_if #(.NRN_W(NRN_W)) op_bus ();
    fc_acc_if #(.NRN_W(NRN_W)) acc_bus ();

    fc_store #(.WADDR_W(WADDR_W), .FADDR_W(FADDR_W)) u_store (
        .clk, .rstn, .load_en, .load_sel, .load_addr, .load_data,
        .feature_raddr, .weight_raddr, .feature_rdata, .weight_rdata,
        .hid_we, .hid_addr, .hid_data
    );

    fc_decode #(
        .N_IN(N_IN), .N_HID(N_HID), .N_OUT(N_OUT),
        .WADDR_W(WADDR_W), .FADDR_W(FADDR_W), .NRN_W(NRN_W)
    ) u_decode (
        .clk, .rstn, .start, .done, .feature_rdata, .weight_rdata,
        .busy, .feature_raddr, .weight_raddr, .op(op_bus)
    );

    fc_execute u_execute (.clk, .rstn, .op(op_bus), .acc_out(acc_bus));

    fc_result #(
        .N_IN(N_IN), .N_OUT(N_OUT), .SHIFT(SHIFT), .FADDR_W(FADDR_W), .NRN_W(NRN_W)
    ) u_result (
        .clk, .rstn, .acc_in(acc_bus), .hid_we, .hid_addr, .hid_data, .class_out, .done
    );

endmodule

// File: sim.f
rtl/fc_pkg.sv
rtl/fc_operand_if.sv
rtl/fc_acc_if.sv
rtl/fc_store.sv
rtl/fc_decode.sv
rtl/fc_execute.sv
rtl/fc_result.sv
rtl/fc_top.sv
sim/fc_tb.sv

// File: sim/fc_tb.sv
module fc_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import fc_pkg::*;

    localparam int N_IN    = 16;
    localparam int N_HID   = 8;
    localparam int N_OUT   = 4;
    localparam int SHIFT   = 4;
    localparam int WADDR_W = 6;
    localparam int FADDR_W = 3;
    localparam int CLS_W   = $clog2(N_OUT);

    // Bound on one classification run, in cycles
    localparam int RUN_TIMEOUT  = 1000;
    localparam int BUSY_TIMEOUT = 10;
    // Quiet cycles after done, no second done may show up
    localparam int HOLD_CYCLES  = 100;

    logic               clk = 1'b0;
    logic               rstn;
    logic               start;
    logic               load_en;
    logic               load_sel;
    logic [WADDR_W-1:0] load_addr;
    fc_word_t           load_data;
    logic               busy;
    logic               done;
    logic [CLS_W-1:0]   class_out;

    int                 fd;
    int                 code;
    int                 num_tests;
    logic [63:0]        tag;
    logic [8*160-1:0]   line_buf;
    logic [31:0]        base;
    logic [31:0]        exp_class;
    fc_word_t           rec_word [LANES];

    always #5 clk = ~clk;

    fc_top #(
        .N_IN(N_IN), .N_HID(N_HID), .N_OUT(N_OUT),
        .SHIFT(SHIFT), .WADDR_W(WADDR_W), .FADDR_W(FADDR_W)
    ) DUT (
        .clk, .rstn, .start, .load_en, .load_sel, .load_addr, .load_data,
        .busy, .done, .class_out
    );

    task automatic stop_on_failure();
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, actual, expected);
            stop_on_failure();
        end
    endtask

    // Four consecutive words from base into the selected memory
    task automatic load_words(input logic sel, input logic [WADDR_W-1:0] addr);
        for (int i = 0; i < LANES; i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_sel  <= sel;
            load_addr <= addr + WADDR_W'(i);
            load_data <= rec_word[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
    endtask

    task automatic wait_for_busy();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!busy) begin
            if (cycles == BUSY_TIMEOUT) begin
                $display("Timeout: busy did not rise after start");
                stop_on_failure();
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic wait_for_done();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!done) begin
            if (cycles == RUN_TIMEOUT) begin
                $display("Timeout: done never pulsed during a classification run");
                stop_on_failure();
            end
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic run_and_check(input logic [31:0] expected);
        load_words(1'b0, '0);
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        wait_for_busy();
        // A second start in the middle of the run
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        wait_for_done();
        check_value("class_out", 32'(class_out), expected);
        check_value("busy", 32'(busy), 32'h0);
        for (int i = 0; i < HOLD_CYCLES; i++) begin
            @(negedge clk);
            check_value("done", 32'(done), 32'h0);
            check_value("busy", 32'(busy), 32'h0);
            check_value("class_out", 32'(class_out), expected);
        end
    endtask

    initial begin
        rstn      = 1'b0;
        start     = 1'b0;
        load_en   = 1'b0;
        load_sel  = 1'b0;
        load_addr = '0;
        load_data = '0;
        num_tests = 0;

        fd = $fopen("sim/fc_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file sim/fc_vectors.txt");
            stop_on_failure();
        end

        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_value("busy", 32'(busy), 32'h0);
        check_value("done", 32'(done), 32'h0);
        check_value("class_out", 32'(class_out), 32'h0);

        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1) begin
                break;
            end
            if (tag == "#") begin
                code = $fgets(line_buf, fd);
            end else if (tag == "W") begin
                code = $fscanf(fd, "%h %h %h %h %h", base,
                               rec_word[0], rec_word[1], rec_word[2], rec_word[3]);
                if (code != 5) begin
                    $display("Malformed weight record in the vector file");
                    stop_on_failure();
                end
                load_words(1'b1, base[WADDR_W-1:0]);
            end else if (tag == "T") begin
                code = $fscanf(fd, "%h %h %h %h %d",
                               rec_word[0], rec_word[1], rec_word[2], rec_word[3], exp_class);
                if (code != 5) begin
                    $display("Malformed test record in the vector file");
                    stop_on_failure();
                end
                run_and_check(exp_class);
                num_tests++;
                $display("Record %0d classified as %0d", num_tests, class_out);
            end else begin
                $display("Unknown record type in the vector file");
                stop_on_failure();
            end
        end
        $fclose(fd);

        if (num_tests == 0) begin
            $display("The vector file held no test records");
            stop_on_failure();
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// File: sim/fc_vectors.txt
# W <base> <w0> <w1> <w2> <w3> : four weight memory words from base, all hex
# T <x0> <x1> <x2> <x3> <class> : four feature words in hex, expected class in decimal
# Layer 0, hidden n adds features 2n and 2n+1 with weight 16
W 00 00001010 00000000 00000000 00000000
W 04 10100000 00000000 00000000 00000000
W 08 00000000 00001010 00000000 00000000
W 0C 00000000 10100000 00000000 00000000
W 10 00000000 00000000 00001010 00000000
W 14 00000000 00000000 10100000 00000000
W 18 00000000 00000000 00000000 00001010
W 1C 00000000 00000000 00000000 10100000
# Layer 0 biases (hidden 1 gets -1), then layer 1 weights of output 0
W 20 0000FF00 00000000 00001010 00000000
# Layer 1 weights of outputs 1 and 2
W 24 10100000 00000000 00000000 00001010
# Layer 1 weights of output 3, then layer 1 biases (output 2 gets -16, output 3 gets 32)
W 28 00000000 10100000 20F00000 00000000
# Plain case
T 01010203 02000004 0303050A 00050101 2
# Output bias decides, class 0 without it
T 00000505 00000000 00000000 05000004 3
# Negative hidden sums, class 3 without ReLU
T 000800EC 00E20006 000500CE 00010002 0
# Tie on the maximum goes to the lower index
T 00010003 00050005 00000000 00040004 1
# Hidden and output saturation, class 1 without it
T 001F6464 7D7D7F7F 0000000A 00000000 0
# Output 0 now reads hidden 4 and 5, output 1 rewritten unchanged
W 22 00000000 00001010 10100000 00000000
T 01010203 02000004 0303050A 00050101 0
T 00000505 00000000 00000000 05000004 3
T 00010003 00050005 00000000 00040004 1
T 001F6464 7D7D7F7F 0000000A 00000000 1
